//--- common/cnn_pkg.sv
package cnn_pkg;

    // ------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------
    // activations and weights share one 8-bit signed format
    typedef logic signed [7:0]  act_t;
    // accumulator wide enough for k*k*ic products
    typedef logic signed [31:0] psum_t;

    // image coordinate, rows and columns up to 63
    typedef logic [5:0]  pix_t;
    // engine-side read address, trimmed by each buffer
    typedef logic [19:0] eng_addr_t;

    // ------------------------------------------------------------
    // run configuration
    // ------------------------------------------------------------
    // held stable by the host from start until done
    typedef struct packed {
        logic [1:0] k;
        logic [9:0] ic;
        pix_t       img_h;
        pix_t       img_w;
        logic [7:0] oc;
        logic [2:0] stride;
        logic [3:0] shift_n;
    } cfg_t;

    // top-level run FSM
    typedef enum logic [1:0] {
        st_idle,
        st_working,
        st_done
    } run_state_t;

    // engine read request into a global buffer
    typedef struct packed {
        logic      en;
        eng_addr_t addr;
    } eng_rd_t;

endpackage

//--- compile.f
common/cnn_pkg.sv
hw/out_mem.sv
glb/glb_bank_ctrl.sv
glb/ping_pong_buf.sv
conv/conv_addr_gen.sv
conv/mac_quant.sv
hw/cnn_top.sv
testbench/cnn_checker.sv
testbench/tb_clock_gen.sv
testbench/tb_top.sv

//--- conv/conv_addr_gen.sv
`timescale 1ns/1ps

module conv_addr_gen import cnn_pkg::*; #(
    parameter int out_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  run_go,
    input  cfg_t                  cfg,
    output eng_rd_t               in_rd,
    output eng_rd_t               w_rd,
    output logic                  item_valid,
    output logic                  acc_first,
    output logic                  acc_last,
    output logic [out_addr_w-1:0] out_addr,
    output logic                  eng_done
);

    // ------------------------------------------------------------
    // loop state
    // ------------------------------------------------------------
    logic                  active;
    pix_t                  oy;
    pix_t                  ox;
    logic [7:0]            o;
    logic [1:0]            ky;
    logic [1:0]            kx;
    logic [9:0]            c;
    // window origin of the current output row and pixel
    eng_addr_t             line_base;
    eng_addr_t             pos_base;
    // start of current kernel row
    eng_addr_t             ky_base;
    eng_addr_t             act_addr;
    eng_addr_t             w_addr;
    logic [out_addr_w-1:0] out_cnt;
    logic                  fin_q;

    // strides in the HWC layout
    eng_addr_t row_len;
    eng_addr_t step_x;
    eng_addr_t step_y;
    logic [7:0] x_next_end;
    logic [7:0] y_next_end;
    logic c_last, kx_last, ky_last, o_last, ox_last, oy_last;
    logic first_tap;
    logic last_tap;

    assign row_len = eng_addr_t'(cfg.img_w) * eng_addr_t'(cfg.ic);
    assign step_x  = eng_addr_t'(cfg.stride) * eng_addr_t'(cfg.ic);
    assign step_y  = eng_addr_t'(cfg.stride) * row_len;

    // next window would run past the image edge
    assign x_next_end = 8'(ox) + 8'(cfg.stride) + 8'(cfg.k);
    assign y_next_end = 8'(oy) + 8'(cfg.stride) + 8'(cfg.k);

    assign c_last  = (c == cfg.ic - 10'd1);
    assign kx_last = (kx == cfg.k - 2'd1);
    assign ky_last = (ky == cfg.k - 2'd1);
    assign o_last  = (o == cfg.oc - 8'd1);
    assign ox_last = (x_next_end > 8'(cfg.img_w));
    assign oy_last = (y_next_end > 8'(cfg.img_h));

    assign first_tap = (c == 10'd0) && (kx == 2'd0) && (ky == 2'd0);
    assign last_tap  = c_last && kx_last && ky_last;

    // ------------------------------------------------------------
    // counters, order oy ox o ky kx c
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            active    <= 1'b0;
            oy        <= '0;
            ox        <= '0;
            o         <= '0;
            ky        <= '0;
            kx        <= '0;
            c         <= '0;
            line_base <= '0;
            pos_base  <= '0;
            ky_base   <= '0;
            act_addr  <= '0;
            w_addr    <= '0;
            out_cnt   <= '0;
        end else if (run_go) begin
            active    <= 1'b1;
            oy        <= '0;
            ox        <= '0;
            o         <= '0;
            ky        <= '0;
            kx        <= '0;
            c         <= '0;
            line_base <= '0;
            pos_base  <= '0;
            ky_base   <= '0;
            act_addr  <= '0;
            w_addr    <= '0;
            out_cnt   <= '0;
        end else if (active) begin
            // weights for one pixel are contiguous
            w_addr <= w_addr + 1'b1;
            if (last_tap) begin
                out_cnt <= out_cnt + 1'b1;
            end
            if (!c_last) begin
                c        <= c + 1'b1;
                act_addr <= act_addr + 1'b1;
            end else if (!kx_last) begin
                // channels and columns sit back to back
                c        <= '0;
                kx       <= kx + 1'b1;
                act_addr <= act_addr + 1'b1;
            end else if (!ky_last) begin
                c        <= '0;
                kx       <= '0;
                ky       <= ky + 1'b1;
                ky_base  <= ky_base + row_len;
                act_addr <= ky_base + row_len;
            end else if (!o_last) begin
                // same window again for the next filter
                c        <= '0;
                kx       <= '0;
                ky       <= '0;
                o        <= o + 1'b1;
                ky_base  <= pos_base;
                act_addr <= pos_base;
            end else begin
                c      <= '0;
                kx     <= '0;
                ky     <= '0;
                o      <= '0;
                w_addr <= '0;
                if (!ox_last) begin
                    ox       <= ox + pix_t'(cfg.stride);
                    pos_base <= pos_base + step_x;
                    ky_base  <= pos_base + step_x;
                    act_addr <= pos_base + step_x;
                end else if (!oy_last) begin
                    ox        <= '0;
                    oy        <= oy + pix_t'(cfg.stride);
                    line_base <= line_base + step_y;
                    pos_base  <= line_base + step_y;
                    ky_base   <= line_base + step_y;
                    act_addr  <= line_base + step_y;
                end else begin
                    // last tap of the last output
                    active <= 1'b0;
                end
            end
        end
    end

    assign in_rd.en   = active;
    assign in_rd.addr = act_addr;
    assign w_rd.en    = active;
    assign w_rd.addr  = w_addr;

    // ------------------------------------------------------------
    // align with the buffer read latency
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            item_valid <= 1'b0;
            acc_first  <= 1'b0;
            acc_last   <= 1'b0;
            fin_q      <= 1'b0;
            eng_done   <= 1'b0;
        end else begin
            item_valid <= active;
            acc_first  <= active && first_tap;
            acc_last   <= active && last_tap;
            fin_q      <= active && last_tap && o_last && ox_last && oy_last;
            // lines up with the final out_mem write
            eng_done   <= fin_q;
        end
    end

    always_ff @(posedge clk) begin
        out_addr <= out_cnt;
    end

endmodule

//--- conv/mac_quant.sv
`timescale 1ns/1ps

module mac_quant import cnn_pkg::*; #(
    parameter int out_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  item_valid,
    input  logic                  acc_first,
    input  logic                  acc_last,
    input  logic [out_addr_w-1:0] out_addr,
    input  act_t                  act,
    input  act_t                  wgt,
    input  logic [3:0]            shift_n,
    output logic                  out_we,
    output logic [out_addr_w-1:0] out_waddr,
    output act_t                  out_wdata
);

    psum_t acc;
    psum_t prod;
    psum_t sum;
    psum_t shifted;
    act_t  sat_val;

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    // signed 8x8, extended to 32 by context
    assign prod = act * wgt;
    // first tap restarts the sum
    assign sum     = acc_first ? prod : acc + prod;
    assign shifted = sum >>> shift_n;

    // clamp to the int8 range
    always_comb begin
        if (shifted > 32'sd127) begin
            sat_val = 8'sd127;
        end else if (shifted < -32'sd128) begin
            sat_val = -8'sd128;
        end else begin
            sat_val = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (item_valid) begin
            acc <= sum;
        end
        // result written one cycle after the last tap
        if (item_valid && acc_last) begin
            out_waddr <= out_addr;
            out_wdata <= sat_val;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            out_we <= 1'b0;
        end else begin
            out_we <= item_valid && acc_last;
        end
    end

endmodule

//--- glb/glb_bank_ctrl.sv
`timescale 1ns/1ps

module glb_bank_ctrl import cnn_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic start,
    input  logic eng_done,
    output logic run_go,
    output logic done,
    output logic busy,
    output logic eng_bank,
    output logic host_bank
);

    run_state_t state;
    run_state_t state_n;

    // ------------------------------------------------------------
    // run FSM
    // ------------------------------------------------------------
    always_comb begin
        state_n = state;
        case (state)
            // start only counts while idle
            st_idle:    if (start) state_n = st_working;
            st_working: if (eng_done) state_n = st_done;
            // single cycle
            st_done:    state_n = st_idle;
            default:    state_n = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= st_idle;
            run_go   <= 1'b0;
            eng_bank <= 1'b0;
        end else begin
            state  <= state_n;
            // pulse in the first working cycle
            run_go <= (state == st_idle) && start;
            // swap banks once the run has finished
            if (state == st_done) begin
                eng_bank <= ~eng_bank;
            end
        end
    end

    assign done = (state == st_done);
    assign busy = (state == st_working);

    // host gets the spare bank only while the engine is running
    assign host_bank = busy ? ~eng_bank : eng_bank;

endmodule

//--- glb/ping_pong_buf.sv
`timescale 1ns/1ps

module ping_pong_buf import cnn_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              host_bank,
    input  logic              eng_bank,
    // host port
    input  logic              en,
    input  logic              we,
    input  logic [addr_w-1:0] addr,
    input  act_t              wdata,
    output act_t              rdata,
    // engine read port
    input  eng_rd_t           eng_rd,
    output act_t              eng_data
);

    localparam int depth = 2 ** addr_w;

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    // bank 0 and bank 1
    act_t bank_mem [2][depth];

    // engine only needs the low bits of its request
    logic [addr_w-1:0] eng_addr;

    assign eng_addr = eng_rd.addr[addr_w-1:0];

    // host side, write and read share one address
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                bank_mem[host_bank][addr] <= wdata;
            end
            // old contents on a write cycle
            rdata <= bank_mem[host_bank][addr];
        end
    end

    // ------------------------------------------------------------
    // engine side
    // ------------------------------------------------------------
    // data one cycle after the request
    always_ff @(posedge clk) begin
        if (eng_rd.en) begin
            eng_data <= bank_mem[eng_bank][eng_addr];
        end
    end

endmodule

//--- hw/cnn_top.sv
`timescale 1ns/1ps

module cnn_top import cnn_pkg::*; #(
    parameter int in_addr_w  = 10,
    parameter int w_addr_w   = 10,
    parameter int out_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  cfg_t                  cfg,
    // activation host port
    input  logic                  in_en,
    input  logic                  in_we,
    input  logic [in_addr_w-1:0]  in_addr,
    input  act_t                  in_wdata,
    output act_t                  in_rdata,
    // weight host port
    input  logic                  w_en,
    input  logic                  w_we,
    input  logic [w_addr_w-1:0]   w_addr,
    input  act_t                  w_wdata,
    output act_t                  w_rdata,
    // output readback port
    input  logic                  out_en,
    input  logic [out_addr_w-1:0] out_addr,
    output act_t                  out_rdata,
    output logic                  done,
    output logic                  busy
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    logic                  run_go;
    logic                  eng_done;
    logic                  eng_bank;
    logic                  host_bank;
    eng_rd_t               in_rd;
    eng_rd_t               w_rd;
    act_t                  act_data;
    act_t                  wgt_data;
    logic                  item_valid;
    logic                  acc_first;
    logic                  acc_last;
    logic [out_addr_w-1:0] item_out_addr;
    logic                  res_we;
    logic [out_addr_w-1:0] res_waddr;
    act_t                  res_wdata;

    // run FSM and bank selection
    glb_bank_ctrl u_bank_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .eng_done  (eng_done),
        .run_go    (run_go),
        .done      (done),
        .busy      (busy),
        .eng_bank  (eng_bank),
        .host_bank (host_bank)
    );

    // activation ping-pong buffer
    ping_pong_buf #(.addr_w(in_addr_w)) u_in_buf (
        .clk       (clk),
        .host_bank (host_bank),
        .eng_bank  (eng_bank),
        .en        (in_en),
        .we        (in_we),
        .addr      (in_addr),
        .wdata     (in_wdata),
        .rdata     (in_rdata),
        .eng_rd    (in_rd),
        .eng_data  (act_data)
    );

    // weight ping-pong buffer
    ping_pong_buf #(.addr_w(w_addr_w)) u_w_buf (
        .clk       (clk),
        .host_bank (host_bank),
        .eng_bank  (eng_bank),
        .en        (w_en),
        .we        (w_we),
        .addr      (w_addr),
        .wdata     (w_wdata),
        .rdata     (w_rdata),
        .eng_rd    (w_rd),
        .eng_data  (wgt_data)
    );

    // ------------------------------------------------------------
    // convolution engine
    // ------------------------------------------------------------
    conv_addr_gen #(.out_addr_w(out_addr_w)) u_addr_gen (
        .clk        (clk),
        .resetn     (resetn),
        .run_go     (run_go),
        .cfg        (cfg),
        .in_rd      (in_rd),
        .w_rd       (w_rd),
        .item_valid (item_valid),
        .acc_first  (acc_first),
        .acc_last   (acc_last),
        .out_addr   (item_out_addr),
        .eng_done   (eng_done)
    );

    mac_quant #(.out_addr_w(out_addr_w)) u_mac (
        .clk        (clk),
        .resetn     (resetn),
        .item_valid (item_valid),
        .acc_first  (acc_first),
        .acc_last   (acc_last),
        .out_addr   (item_out_addr),
        .act        (act_data),
        .wgt        (wgt_data),
        .shift_n    (cfg.shift_n),
        .out_we     (res_we),
        .out_waddr  (res_waddr),
        .out_wdata  (res_wdata)
    );

    // results, host reads back after done
    out_mem #(.out_addr_w(out_addr_w)) u_out_mem (
        .clk   (clk),
        .we    (res_we),
        .waddr (res_waddr),
        .wdata (res_wdata),
        .rd_en (out_en),
        .raddr (out_addr),
        .rdata (out_rdata)
    );

endmodule

//--- hw/out_mem.sv
`timescale 1ns/1ps

module out_mem import cnn_pkg::*; #(
    parameter int out_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [out_addr_w-1:0] waddr,
    input  act_t                  wdata,
    input  logic                  rd_en,
    input  logic [out_addr_w-1:0] raddr,
    output act_t                  rdata
);

    // engine writes, host reads
    act_t mem [2 ** out_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (rd_en) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result from simulation"; exit 1; }
exit 0

//--- testbench/cnn_checker.sv
`timescale 1ns/1ps

module cnn_checker (
    input logic clk,
    input logic resetn,
    input logic done,
    input logic busy,
    input logic eng_bank
);

    // failed assertions so far, summed into the final error count
    int n_fail = 0;

    // ------------------------------------------------------------
    // run FSM properties
    // ------------------------------------------------------------
    // done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clk) disable iff (!resetn) done |=> !done
    ) else begin
        $error("done stayed high for more than one cycle");
        n_fail++;
    end

    // working and done are separate states
    busy_done_excl: assert property (
        @(posedge clk) disable iff (!resetn) !(busy && done)
    ) else begin
        $error("busy and done high in the same cycle");
        n_fail++;
    end

    // banks swap only right after a finished run
    bank_swap_after_done: assert property (
        @(posedge clk) disable iff (!resetn)
        (eng_bank != $past(eng_bank)) |-> $past(done)
    ) else begin
        $error("eng_bank changed outside the cycle after done");
        n_fail++;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic resetn
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top import cnn_pkg::*; ();

    localparam int in_addr_w  = 10;
    localparam int w_addr_w   = 10;
    localparam int out_addr_w = 8;
    localparam int n_rows     = 4;
    // words read back from a bank after loading or after a run
    localparam int n_peek     = 8;

    // data modes of a table row
    localparam int mode_rand  = 0;
    localparam int mode_large = 1;
    localparam int mode_small = 2;

    logic                  clk;
    logic                  resetn;
    logic                  start;
    cfg_t                  cfg;
    logic                  in_en;
    logic                  in_we;
    logic [in_addr_w-1:0]  in_addr;
    act_t                  in_wdata;
    act_t                  in_rdata;
    logic                  w_en;
    logic                  w_we;
    logic [w_addr_w-1:0]   w_addr;
    act_t                  w_wdata;
    act_t                  w_rdata;
    logic                  out_en;
    logic [out_addr_w-1:0] out_addr;
    act_t                  out_rdata;
    logic                  done;
    logic                  busy;

    int n_checks = 0;
    int n_errors = 0;
    logic [15:0] lfsr = 16'd54881;

    // shadow copies of both banks, index is the bank
    act_t act_sh [2][2 ** in_addr_w];
    act_t wgt_sh [2][2 ** w_addr_w];

    // ------------------------------------------------------------
    // run table
    // ------------------------------------------------------------
    // output count sizes the watchdog, need_sat asks for both int8 rails
    typedef struct {
        cfg_t cfg;
        int   mode;
        int   n_out;
        bit   need_sat;
    } row_t;

    row_t runs [n_rows];

    tb_clock_gen #(.period_ns(20), .reset_cycles(3)) u_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    cnn_top #(
        .in_addr_w  (in_addr_w),
        .w_addr_w   (w_addr_w),
        .out_addr_w (out_addr_w)
    ) cnn_top_inst (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .cfg       (cfg),
        .in_en     (in_en),
        .in_we     (in_we),
        .in_addr   (in_addr),
        .in_wdata  (in_wdata),
        .in_rdata  (in_rdata),
        .w_en      (w_en),
        .w_we      (w_we),
        .w_addr    (w_addr),
        .w_wdata   (w_wdata),
        .w_rdata   (w_rdata),
        .out_en    (out_en),
        .out_addr  (out_addr),
        .out_rdata (out_rdata),
        .done      (done),
        .busy      (busy)
    );

    bind glb_bank_ctrl cnn_checker u_checker (
        .clk      (clk),
        .resetn   (resetn),
        .done     (done),
        .busy     (busy),
        .eng_bank (eng_bank)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic cfg_t make_cfg(input int k, input int ic, input int h, input int w,
                                      input int oc, input int stride, input int shift_n);
        cfg_t cf;
        cf.k       = 2'(k);
        cf.ic      = 10'(ic);
        cf.img_h   = pix_t'(h);
        cf.img_w   = pix_t'(w);
        cf.oc      = 8'(oc);
        cf.stride  = 3'(stride);
        cf.shift_n = 4'(shift_n);
        return cf;
    endfunction

    // HWC image size
    function automatic int act_words(input cfg_t cf);
        return int'(cf.img_h) * int'(cf.img_w) * int'(cf.ic);
    endfunction

    function automatic int wgt_words(input cfg_t cf);
        return int'(cf.oc) * int'(cf.k) * int'(cf.k) * int'(cf.ic);
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic next_value(input int mode, input bit is_wgt, output act_t v);
        logic [7:0] b;
        if (mode == mode_small) begin
            // signed 4-bit range
            rand_bits(4, b);
            v = act_t'({{4{b[3]}}, b[3:0]});
        end else if (mode == mode_large && is_wgt) begin
            rand_bits(1, b);
            v = b[0] ? -8'sd127 : 8'sd127;
        end else begin
            rand_bits(8, b);
            v = act_t'(b);
        end
    endtask

    task automatic check_value(input int got, input int exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at time %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    // valid conv, sum >>> shift_n, clamp to int8
    function automatic act_t model_out(input int row, input int bank,
                                       input int oy, input int ox, input int o);
        cfg_t cf;
        int   s;
        int   ay;
        int   ax;
        int   aa;
        int   wa;
        cf = runs[row].cfg;
        s  = 0;
        for (int ky = 0; ky < int'(cf.k); ky++) begin
            for (int kx = 0; kx < int'(cf.k); kx++) begin
                for (int c = 0; c < int'(cf.ic); c++) begin
                    ay = oy * int'(cf.stride) + ky;
                    ax = ox * int'(cf.stride) + kx;
                    aa = (ay * int'(cf.img_w) + ax) * int'(cf.ic) + c;
                    wa = ((o * int'(cf.k) + ky) * int'(cf.k) + kx) * int'(cf.ic) + c;
                    s  = s + int'(act_sh[bank][aa]) * int'(wgt_sh[bank][wa]);
                end
            end
        end
        s = s >>> cf.shift_n;
        if (s > 127) begin
            return 8'sd127;
        end
        if (s < -128) begin
            return -8'sd128;
        end
        return act_t'(s);
    endfunction

    // ------------------------------------------------------------
    // host port tasks
    // ------------------------------------------------------------
    // activations and weights go in side by side, one word each per cycle
    task automatic load_bank(input int row, input int bank);
        int   n_act;
        int   n_wgt;
        act_t v;
        n_act = act_words(runs[row].cfg);
        n_wgt = wgt_words(runs[row].cfg);
        for (int i = 0; i < n_act || i < n_wgt; i++) begin
            @(negedge clk);
            in_en = (i < n_act);
            in_we = (i < n_act);
            w_en  = (i < n_wgt);
            w_we  = (i < n_wgt);
            if (i < n_act) begin
                next_value(runs[row].mode, 1'b0, v);
                in_addr  = in_addr_w'(i);
                in_wdata = v;
                act_sh[bank][i] = v;
            end
            if (i < n_wgt) begin
                next_value(runs[row].mode, 1'b1, v);
                w_addr  = w_addr_w'(i);
                w_wdata = v;
                wgt_sh[bank][i] = v;
            end
        end
        @(negedge clk);
        in_en = 1'b0;
        in_we = 1'b0;
        w_en  = 1'b0;
        w_we  = 1'b0;
    endtask

    // first words of whatever bank the host port reaches now
    task automatic read_back(input int bank, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_en   = 1'b1;
            in_we   = 1'b0;
            in_addr = in_addr_w'(i);
            w_en    = 1'b1;
            w_we    = 1'b0;
            w_addr  = w_addr_w'(i);
            @(negedge clk);
            in_en = 1'b0;
            w_en  = 1'b0;
            check_value(int'(in_rdata), int'(act_sh[bank][i]),
                        $sformatf("act readback bank %0d addr %0d", bank, i));
            check_value(int'(w_rdata), int'(wgt_sh[bank][i]),
                        $sformatf("weight readback bank %0d addr %0d", bank, i));
        end
    endtask

    task automatic check_outputs(input int row, input int bank);
        cfg_t cf;
        int   oh;
        int   ow;
        int   addr;
        int   n_hi;
        int   n_lo;
        act_t exp_v;
        cf   = runs[row].cfg;
        oh   = (int'(cf.img_h) - int'(cf.k)) / int'(cf.stride) + 1;
        ow   = (int'(cf.img_w) - int'(cf.k)) / int'(cf.stride) + 1;
        n_hi = 0;
        n_lo = 0;
        for (int oy = 0; oy < oh; oy++) begin
            for (int ox = 0; ox < ow; ox++) begin
                for (int o = 0; o < int'(cf.oc); o++) begin
                    addr = (oy * ow + ox) * int'(cf.oc) + o;
                    @(negedge clk);
                    out_en   = 1'b1;
                    out_addr = out_addr_w'(addr);
                    @(negedge clk);
                    out_en = 1'b0;
                    exp_v  = model_out(row, bank, oy, ox, o);
                    check_value(int'(out_rdata), int'(exp_v),
                                $sformatf("run %0d output addr %0d", row, addr));
                    if (out_rdata == 8'sd127) begin
                        n_hi++;
                    end
                    if (out_rdata == -8'sd128) begin
                        n_lo++;
                    end
                end
            end
        end
        if (runs[row].need_sat) begin
            check_value(int'(n_hi > 0), 1, $sformatf("run %0d saturates to 127", row));
            check_value(int'(n_lo > 0), 1, $sformatf("run %0d saturates to -128", row));
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int bank;
        int n_assert;
        start    = 1'b0;
        cfg      = '0;
        in_en    = 1'b0;
        in_we    = 1'b0;
        in_addr  = '0;
        in_wdata = '0;
        w_en     = 1'b0;
        w_we     = 1'b0;
        w_addr   = '0;
        w_wdata  = '0;
        out_en   = 1'b0;
        out_addr = '0;

        // 6x6 k3 s1, 4x4x2 outputs
        runs[0] = '{make_cfg(3, 2, 6, 6, 2, 1, 9), mode_rand, 32, 1'b0};
        // 6x6 k1 s2, 3x3x3 outputs
        runs[1] = '{make_cfg(1, 4, 6, 6, 3, 2, 7), mode_rand, 27, 1'b0};
        // small values, shift by 4 stays in range
        runs[2] = '{make_cfg(3, 3, 5, 5, 2, 1, 4), mode_small, 18, 1'b0};
        // weights of +-127 and no shift
        runs[3] = '{make_cfg(1, 2, 4, 4, 2, 1, 0), mode_large, 32, 1'b1};

        @(posedge resetn);
        @(negedge clk);
        check_value(int'(done), 0, "done after reset");
        check_value(int'(busy), 0, "busy after reset");

        // first run's data goes straight into the idle bank
        load_bank(0, 0);
        read_back(0, n_peek);

        for (int r = 0; r < n_rows; r++) begin
            bank = r % 2;
            @(negedge clk);
            cfg   = runs[r].cfg;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            check_value(int'(busy), 1, $sformatf("busy after start of run %0d", r));
            // host now sees the previous run's bank, still untouched
            if (r > 0) begin
                read_back((r + 1) % 2, n_peek);
            end
            // next run's data into the spare bank
            if (r + 1 < n_rows) begin
                load_bank(r + 1, (r + 1) % 2);
                check_value(int'(busy), 1, $sformatf("run %0d still busy after load", r));
            end
            while (!done) @(negedge clk);
            check_outputs(r, bank);
        end

        n_assert = cnn_top_inst.u_bank_ctrl.u_checker.n_fail;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    // mac cycles plus host traffic per row, doubled for margin
    initial begin
        longint cycles;
        longint limit_ns;
        @(posedge resetn);
        cycles = 0;
        for (int r = 0; r < n_rows; r++) begin
            cycles += longint'(runs[r].n_out) * int'(runs[r].cfg.k) * int'(runs[r].cfg.k)
                      * int'(runs[r].cfg.ic);
            cycles += act_words(runs[r].cfg) + wgt_words(runs[r].cfg);
            cycles += 2 * runs[r].n_out + 4 * n_peek + 50;
        end
        limit_ns = cycles * 20 * 2;
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
